// ==== sources.f ====
+incdir+rtl
rtl/lc3_ctrl_pkg.sv
rtl/pipe_hazard_if.sv
rtl/pipe_sequencer.sv
rtl/branch_bubble_counter.sv
rtl/operand_bypass.sv
rtl/mem_access_ctrl.sv
rtl/lc3_pipe_ctrl.sv
dv/lc3_pipe_ctrl_props.sv
dv/lc3_pipe_ctrl_tb.sv

// ==== dv/lc3_pipe_ctrl_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lc3_ctrl_defines.svh"

module lc3_pipe_ctrl_tb import lc3_ctrl_pkg::*; ();

   logic                   clock;
   logic                   reset;
   logic                   complete_instr;
   logic                   complete_data;
   logic [`LC3_WORD_W-1:0] ir;
   logic [`LC3_WORD_W-1:0] ir_exec;
   logic [`LC3_WORD_W-1:0] instr_dout;
   logic [`LC3_CC_W-1:0]   psr;
   logic [`LC3_CC_W-1:0]   nzp;
   logic                   bypass_alu_1;
   logic                   bypass_alu_2;
   logic                   bypass_mem_1;
   logic                   bypass_mem_2;
   logic                   enable_update_pc;
   logic                   enable_fetch;
   logic                   enable_decode;
   logic                   enable_execute;
   logic                   enable_writeback;
   logic                   br_taken;
   logic                   d_macc;
   mem_state_e             mem_state;

   integer seed = 21;     // register field picks
   integer error_count = 0;
   integer test_count = 0;
   integer failed_tests = 0;
   integer errors_at_start = 0;
   string  current_test = "";

   lc3_pipe_ctrl DUT (.*);

   initial begin
      clock = 1'b0;
      forever #4 clock = ~clock; // 8 ns period
   end

   // enables as {update_pc, fetch, decode, execute, writeback}
   function automatic logic [4:0] enable_vector();
      return {enable_update_pc, enable_fetch, enable_decode, enable_execute, enable_writeback};
   endfunction

   // bypasses as {alu_1, alu_2, mem_1, mem_2}
   function automatic logic [3:0] bypass_vector();
      return {bypass_alu_1, bypass_alu_2, bypass_mem_1, bypass_mem_2};
   endfunction

   // alu op: mode 00, class 01, dr, sr1, imm flag, sr2
   function automatic logic [15:0] alu_word(input logic [2:0] dr, input logic [2:0] sr1,
                                            input logic imm, input logic [2:0] sr2);
      return {2'b00, OC_ALU, dr, sr1, imm, 2'b00, sr2};
   endfunction

   // load/store: mode, class, dr or sr, base register, zero offset
   function automatic logic [15:0] mem_word(input logic [1:0] mode, input logic [1:0] cls,
                                            input logic [2:0] reg_a, input logic [2:0] base);
      return {mode, cls, reg_a, base, 6'b000000};
   endfunction

   task automatic compare_value(input string name, input logic [15:0] expected,
                                input logic [15:0] actual);
      if (actual !== expected) begin
         $display("ERROR %s, %s: expected %h, actual %h", current_test, name,
                  expected, actual);
         error_count++;
      end
   endtask

   task automatic start_test(input string name);
      current_test    = name;
      errors_at_start = error_count;
      test_count++;
   endtask

   task automatic finish_test(input string name);
      if (error_count == errors_at_start) begin
         $display("%s: passed", name);
      end
      else begin
         $display("%s: failed with %0d errors", name, error_count - errors_at_start);
         failed_tests++;
      end
   endtask

   // samples at negedge + 2 until mem_state matches
   task automatic wait_mem_state(input string name, input mem_state_e target,
                                 input integer limit);
      integer n;
      n = 0;
      while (mem_state !== target && n < limit) begin
         @(negedge clock);
         #2;
         n++;
      end
      if (mem_state !== target) begin
         $display("%s: mem_state did not reach %0d within %0d cycles", name, target, limit);
         error_count++;
      end
   endtask

   task automatic wait_fetch(input string name, input integer limit);
      integer n;
      n = 0;
      while (enable_fetch !== 1'b1 && n < limit) begin
         @(negedge clock);
         #2;
         n++;
      end
      if (enable_fetch !== 1'b1) begin
         $display("%s: enable_fetch did not rise within %0d cycles", name, limit);
         error_count++;
      end
   endtask

   // 3 cycles of reset, returns on the negedge where reset drops
   task automatic reset_dut();
      @(negedge clock);
      reset          = 1'b1;
      complete_instr = 1'b0;
      complete_data  = 1'b0;
      ir             = '0;
      ir_exec        = '0;
      instr_dout     = '0;
      psr            = '0;
      nzp            = '0;
      repeat (3) @(posedge clock);
      @(negedge clock);
      reset = 1'b0;
   endtask

   // reset, then steady run with every enable high
   task automatic run_up();
      reset_dut();
      complete_instr = 1'b1;
      ir             = alu_word(3'd0, 3'd0, 1'b0, 3'd0); // nonzero, keeps execute alive
      repeat (4) @(negedge clock);
   endtask

   task automatic startup_enables();
      start_test("startup");
      reset_dut();
      #2;
      compare_value("startup no word", 5'b01000, enable_vector()); // fetch only
      compare_value("startup mem_state", MS_IDLE, mem_state);
      compare_value("startup br d_macc", 2'b00, {br_taken, d_macc});
      compare_value("startup bypass", 4'b0000, bypass_vector());
      @(negedge clock);
      #2;
      compare_value("startup still waiting", 5'b01000, enable_vector());
      @(negedge clock);
      complete_instr = 1'b1;
      #2;
      compare_value("startup first word", 5'b11000, enable_vector());
      @(negedge clock);
      #2;
      compare_value("startup fill", 5'b11100, enable_vector());
      @(negedge clock);
      #2;
      compare_value("startup run, ir nop", 5'b11100, enable_vector()); // execute killed
      finish_test("startup");
   endtask

   // producer one cycle, consumer the next
   task automatic bypass_case(input string name, input logic [15:0] producer,
                              input logic [15:0] consumer, input logic [3:0] expected);
      @(negedge clock);
      ir = producer;
      @(negedge clock);
      ir = consumer;
      #2;
      compare_value(name, expected, bypass_vector());
   endtask

   task automatic alu_bypass_checks();
      logic [2:0]  d;
      logic [2:0]  x;
      logic [15:0] prod;
      start_test("alu bypass");
      run_up();
      d    = $random(seed);
      x    = d ^ 3'b001; // any other register
      prod = alu_word(d, x, 1'b0, x);
      bypass_case("alu src1", prod, alu_word(x, d, 1'b0, x), 4'b1000);
      bypass_case("alu src2", prod, alu_word(x, x, 1'b0, d), 4'b0100);
      bypass_case("alu both", prod, alu_word(x, d, 1'b0, d), 4'b1100);
      bypass_case("alu imm no src2", prod, alu_word(x, x, 1'b1, d), 4'b0000);
      bypass_case("alu imm src1", prod, alu_word(x, d, 1'b1, d), 4'b1000);
      bypass_case("alu no match", prod, alu_word(d, x, 1'b0, x), 4'b0000);
      finish_test("alu bypass");
   endtask

   task automatic memory_bypass_checks();
      logic [2:0]  d;
      logic [2:0]  x;
      logic [15:0] load;
      logic [15:0] lea;
      start_test("memory and lea bypass");
      run_up();
      d    = $random(seed);
      x    = d ^ 3'b010;
      load = mem_word(AM_BASE, OC_LOAD, d, x);
      lea  = mem_word(AM_LEA, OC_LOAD, d, x);
      bypass_case("load to store base", load, mem_word(AM_BASE, OC_STORE, x, d), 4'b0010);
      bypass_case("load to store sr", load, mem_word(AM_BASE, OC_STORE, d, x), 4'b0001);
      bypass_case("load to store both", load, mem_word(AM_BASE, OC_STORE, d, d), 4'b0011);
      // base field ignored outside base mode
      bypass_case("load to indirect store", load,
                  mem_word(AM_INDIRECT, OC_STORE, d, d), 4'b0001);
      bypass_case("load to alu", load, alu_word(x, d, 1'b0, d), 4'b0011);
      bypass_case("lea to store both", lea, mem_word(AM_BASE, OC_STORE, d, d), 4'b1100);
      finish_test("memory and lea bypass");
   endtask

   task automatic load_stall();
      start_test("load stall");
      run_up();
      @(negedge clock);
      ir_exec = mem_word(AM_BASE, OC_LOAD, 3'd1, 3'd2);
      #2;
      wait_mem_state("load request", MS_LOAD, 4);
      compare_value("load d_macc", 1'b1, d_macc);
      compare_value("load enables", 5'b00000, enable_vector());
      repeat (3) begin // memory slow to answer
         @(negedge clock);
         #2;
         compare_value("load wait mem_state", MS_LOAD, mem_state);
         compare_value("load wait d_macc", 1'b1, d_macc);
         compare_value("load wait enables", 5'b00000, enable_vector());
      end
      @(negedge clock);
      complete_data = 1'b1;
      #2;
      compare_value("load done mem_state", MS_IDLE, mem_state);
      compare_value("load done d_macc", 1'b0, d_macc);
      compare_value("load done enables", 5'b11111, enable_vector());
      @(negedge clock);
      complete_data = 1'b0;
      ir_exec       = '0;
      #2;
      compare_value("load after mem_state", MS_IDLE, mem_state);
      finish_test("load stall");
   endtask

   task automatic indirect_store();
      start_test("indirect store");
      run_up();
      @(negedge clock);
      ir_exec = mem_word(AM_INDIRECT, OC_STORE, 3'd3, 3'd4);
      #2;
      wait_mem_state("indirect request", MS_INDIRECT, 4);
      compare_value("indirect d_macc", 1'b1, d_macc);
      @(negedge clock);
      #2;
      compare_value("indirect pointer wait", MS_INDIRECT, mem_state);
      @(negedge clock);
      complete_data = 1'b1; // pointer back
      #2;
      compare_value("indirect pointer done", MS_STORE, mem_state);
      compare_value("indirect still stalled", 1'b1, d_macc);
      @(negedge clock);
      complete_data = 1'b0;
      #2;
      compare_value("indirect store wait", MS_STORE, mem_state);
      compare_value("indirect store enables", 5'b00000, enable_vector());
      @(negedge clock);
      complete_data = 1'b1;
      #2;
      compare_value("indirect store done", MS_IDLE, mem_state);
      compare_value("indirect writeback", 1'b0, enable_writeback);
      compare_value("indirect done enables", 5'b11110, enable_vector());
      compare_value("indirect done d_macc", 1'b0, d_macc);
      @(negedge clock);
      complete_data = 1'b0;
      ir_exec       = '0;
      finish_test("indirect store");
   endtask

   // control word held on instr_dout through the bubbles
   task automatic branch_case(input string name, input logic [2:0] cc,
                              input logic [2:0] mask, input logic taken);
      run_up();
      psr        = cc;
      nzp        = mask;
      instr_dout = 16'h0E05; // br nzp, offset 5
      #2;
      compare_value({name, " bubble 0"}, 3'b000, {enable_update_pc, enable_fetch, br_taken});
      @(negedge clock);
      #2;
      compare_value({name, " bubble 1"}, 3'b000, {enable_update_pc, enable_fetch, br_taken});
      @(negedge clock);
      #2;
      compare_value({name, " br_taken"}, taken, br_taken);
      compare_value({name, " resolve"}, {taken, 3'b000},
                    {enable_update_pc, enable_fetch, enable_decode, enable_writeback});
      wait_fetch({name, " refill"}, 4);
      compare_value({name, " refill enables"}, 5'b01000, enable_vector());
      compare_value({name, " refill br_taken"}, 1'b0, br_taken);
      @(negedge clock);
      instr_dout = '0; // target word arrives
      #2;
      compare_value({name, " restart"}, 2'b11, {enable_update_pc, enable_fetch});
   endtask

   task automatic branch_bubbles();
      start_test("branch");
      branch_case("branch taken", 3'b010, 3'b010, 1'b1);     // z shared
      branch_case("branch not taken", 3'b100, 3'b011, 1'b0); // n against zp
      finish_test("branch");
   endtask

   initial begin
      reset          = 1'b1;
      complete_instr = 1'b0;
      complete_data  = 1'b0;
      ir             = '0;
      ir_exec        = '0;
      instr_dout     = '0;
      psr            = '0;
      nzp            = '0;
      startup_enables();
      alu_bypass_checks();
      memory_bypass_checks();
      load_stall();
      indirect_store();
      branch_bubbles();
      $display("tests run %0d, tests failed %0d, checks failed %0d",
               test_count, failed_tests, error_count);
      if (error_count == 0) begin
         $display("TEST RESULT: PASS");
      end
      else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== dv/lc3_pipe_ctrl_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc3_pipe_ctrl_props import lc3_ctrl_pkg::*; (
   input wire logic       clock,
   input wire logic       reset,
   input wire logic       d_macc,
   input wire logic       enable_update_pc,
   input wire logic       enable_fetch,
   input wire logic       enable_decode,
   input wire logic       enable_execute,
   input wire logic       enable_writeback,
   input wire logic       br_taken,
   input wire logic [1:0] mem_state
);

   // memory stall freezes every stage
   stall_freezes_pipe : assert property (@(posedge clock) disable iff (reset)
      d_macc |-> !(enable_update_pc || enable_fetch || enable_decode ||
                   enable_execute || enable_writeback))
      else $error("d_macc high with a stage enable set");

   // decided branch never fetches in the same cycle
   branch_blocks_fetch : assert property (@(posedge clock) disable iff (reset)
      br_taken |-> !enable_fetch)
      else $error("br_taken high together with enable_fetch");

   // memory controller comes out of reset idle
   idle_after_reset : assert property (@(posedge clock)
      reset |=> (mem_state == MS_IDLE))
      else $error("mem_state not idle in the cycle after reset");

endmodule

bind lc3_pipe_ctrl lc3_pipe_ctrl_props u_props (.*);

`default_nettype wire

// ==== rtl/lc3_pipe_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lc3_ctrl_defines.svh"

module lc3_pipe_ctrl import lc3_ctrl_pkg::*; (
   input  wire logic                  clock,
   input  wire logic                  reset,
   input  wire logic                  complete_instr,
   input  wire logic                  complete_data,
   input  wire logic [`LC3_WORD_W-1:0] ir,
   input  wire logic [`LC3_WORD_W-1:0] ir_exec,
   input  wire logic [`LC3_WORD_W-1:0] instr_dout,
   input  wire logic [`LC3_CC_W-1:0]   psr,
   input  wire logic [`LC3_CC_W-1:0]   nzp,
   output logic                       bypass_alu_1,
   output logic                       bypass_alu_2,
   output logic                       bypass_mem_1,
   output logic                       bypass_mem_2,
   output logic                       enable_update_pc,
   output logic                       enable_fetch,
   output logic                       enable_decode,
   output logic                       enable_execute,
   output logic                       enable_writeback,
   output logic                       br_taken,
   output logic                       d_macc,
   output mem_state_e                 mem_state
);

   logic pipe_running; // sequencer in steady state

   pipe_hazard_if hz ();

   pipe_sequencer u_sequencer (
      .clock            (clock),
      .reset            (reset),
      .complete_instr   (complete_instr),
      .ir               (ir),
      .instr_dout       (instr_dout),
      .psr              (psr),
      .nzp              (nzp),
      .hazard           (hz.sequencer),
      .enable_update_pc (enable_update_pc),
      .enable_fetch     (enable_fetch),
      .enable_decode    (enable_decode),
      .enable_execute   (enable_execute),
      .enable_writeback (enable_writeback),
      .br_taken         (br_taken),
      .pipe_running     (pipe_running)
   );

   branch_bubble_counter u_bubble_counter (
      .clock          (clock),
      .reset          (reset),
      .complete_instr (complete_instr),
      .hazard         (hz.counter)
   );

   operand_bypass u_bypass (
      .clock        (clock),
      .reset        (reset),
      .pipe_running (pipe_running),
      .ir           (ir),
      .stall        (hz.stall),
      .bypass_alu_1 (bypass_alu_1),
      .bypass_alu_2 (bypass_alu_2),
      .bypass_mem_1 (bypass_mem_1),
      .bypass_mem_2 (bypass_mem_2)
   );

   mem_access_ctrl u_mem_ctrl (
      .clock         (clock),
      .reset         (reset),
      .complete_data (complete_data),
      .ir_exec       (ir_exec),
      .hazard        (hz.mem),
      .mem_state     (mem_state),
      .d_macc        (d_macc)
   );

endmodule

`default_nettype wire

// ==== rtl/mem_access_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lc3_ctrl_defines.svh"

module mem_access_ctrl import lc3_ctrl_pkg::*; (
   input  wire logic                  clock,
   input  wire logic                  reset,
   input  wire logic                  complete_data,
   input  wire logic [`LC3_WORD_W-1:0] ir_exec,
   pipe_hazard_if.mem                 hazard,
   output mem_state_e                 mem_state,
   output logic                       d_macc
);

   mem_state_e state, next_state;

   op_class_e  exec_class;
   addr_mode_e exec_mode;
   logic       mem_op;     // load or store that touches memory
   logic       is_store;
   logic       stall;
   logic       store_done;

   assign exec_class = op_class_e'(ir_exec[13:12]);
   assign exec_mode  = addr_mode_e'(ir_exec[15:14]);
   assign is_store   = (exec_class == OC_STORE);
   assign mem_op     = ((exec_class == OC_LOAD) || is_store) && (exec_mode != AM_LEA);

   always_comb begin
      next_state = state;
      stall      = 1'b0;
      store_done = 1'b0;
      case (state)
         MS_IDLE: begin
            if (mem_op) begin
               stall = 1'b1; // freeze as soon as execute shows the access
               if (exec_mode == AM_INDIRECT) begin
                  next_state = MS_INDIRECT;
               end
               else begin
                  next_state = is_store ? MS_STORE : MS_LOAD;
               end
            end
         end
         MS_INDIRECT: begin
            stall = 1'b1; // pointer read, stall through its completion
            if (complete_data) begin
               next_state = is_store ? MS_STORE : MS_LOAD;
            end
         end
         MS_LOAD: begin
            if (complete_data) begin
               next_state = MS_IDLE;
            end
            else begin
               stall = 1'b1;
            end
         end
         MS_STORE: begin
            if (complete_data) begin
               next_state = MS_IDLE;
               store_done = 1'b1; // no reg writeback for this one
            end
            else begin
               stall = 1'b1;
            end
         end
         default: begin
            next_state = MS_IDLE;
         end
      endcase
   end

   always_ff @(posedge clock) begin
      if (reset) begin
         state <= MS_IDLE;
      end
      else begin
         state <= next_state;
      end
   end

   assign mem_state         = next_state; // lookahead, dmem sees it this cycle
   assign d_macc            = stall;
   assign hazard.stall      = stall;
   assign hazard.store_done = store_done;

endmodule

`default_nettype wire

// ==== rtl/operand_bypass.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lc3_ctrl_defines.svh"

module operand_bypass import lc3_ctrl_pkg::*; (
   input  wire logic                  clock,
   input  wire logic                  reset,
   input  wire logic                  pipe_running,
   input  wire logic [`LC3_WORD_W-1:0] ir,
   input  wire logic                  stall,
   output logic                       bypass_alu_1,
   output logic                       bypass_alu_2,
   output logic                       bypass_mem_1,
   output logic                       bypass_mem_2
);

   logic [`LC3_WORD_W-1:0] prev_ir;

   op_class_e  cur_class, prev_class;
   addr_mode_e cur_mode, prev_mode;

   logic [`LC3_REG_W-1:0] prev_dr; // producer destination
   logic [`LC3_REG_W-1:0] src1;    // sr1 or baser
   logic [`LC3_REG_W-1:0] src2;    // sr2 or store sr
   logic                  use_src1;
   logic                  use_src2;
   logic                  hit1;
   logic                  hit2;
   logic                  alu_producer;
   logic                  mem_producer;

   // previous instruction, frozen with the pipe
   always_ff @(posedge clock) begin
      if (reset) begin
         prev_ir <= '0; // control class, no producer
      end
      else if (!stall) begin
         prev_ir <= ir;
      end
   end

   assign cur_class  = op_class_e'(ir[13:12]);
   assign cur_mode   = addr_mode_e'(ir[15:14]);
   assign prev_class = op_class_e'(prev_ir[13:12]);
   assign prev_mode  = addr_mode_e'(prev_ir[15:14]);
   assign prev_dr    = prev_ir[11:9];
   assign src1       = ir[8:6];

   // lea result comes off the alu path, real loads come from memory
   assign alu_producer = (prev_class == OC_ALU) ||
                         ((prev_class == OC_LOAD) && (prev_mode == AM_LEA));
   assign mem_producer = (prev_class == OC_LOAD) && (prev_mode != AM_LEA);

   // which source fields the current instruction actually reads
   always_comb begin
      use_src1 = 1'b0;
      use_src2 = 1'b0;
      src2     = ir[2:0];
      case (cur_class)
         OC_ALU: begin
            use_src1 = 1'b1;
            use_src2 = !ir[5];    // bit 5 set means immediate
         end
         OC_CONTROL: begin
            use_src1 = (cur_mode == AM_LEA); // jmp baser
         end
         OC_LOAD: begin
            use_src1 = (cur_mode == AM_BASE);
         end
         OC_STORE: begin
            use_src1 = (cur_mode == AM_BASE);
            use_src2 = 1'b1;      // store data register
            src2     = ir[11:9];
         end
         default: begin
            use_src1 = 1'b0;
         end
      endcase
   end

   assign hit1 = pipe_running && use_src1 && (src1 == prev_dr);
   assign hit2 = pipe_running && use_src2 && (src2 == prev_dr);

   assign bypass_alu_1 = hit1 && alu_producer;
   assign bypass_alu_2 = hit2 && alu_producer;
   assign bypass_mem_1 = hit1 && mem_producer;
   assign bypass_mem_2 = hit2 && mem_producer;

endmodule

`default_nettype wire

// ==== rtl/branch_bubble_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lc3_ctrl_defines.svh"

module branch_bubble_counter (
   input  wire logic     clock,
   input  wire logic     reset,
   input  wire logic     complete_instr,
   pipe_hazard_if.counter hazard
);

   logic at_refill; // fetch restart point
   logic at_max;    // all ones, hold

   assign at_refill = (hazard.bubble_count == `BUBBLE_W'(`BRANCH_REFILL_COUNT));
   assign at_max    = &hazard.bubble_count;

   // rearm once the refill word has arrived
   always_ff @(posedge clock) begin
      if (reset || hazard.count_clear || (at_refill && complete_instr)) begin
         hazard.bubble_count <= '0;
      end
      else if (hazard.count_inc && !hazard.stall && !at_max) begin
         hazard.bubble_count <= hazard.bubble_count + 1'b1; // frozen under stall
      end
   end

endmodule

`default_nettype wire

// ==== rtl/pipe_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lc3_ctrl_defines.svh"

module pipe_sequencer import lc3_ctrl_pkg::*; (
   input  wire logic                  clock,
   input  wire logic                  reset,
   input  wire logic                  complete_instr,
   input  wire logic [`LC3_WORD_W-1:0] ir,
   input  wire logic [`LC3_WORD_W-1:0] instr_dout,
   input  wire logic [`LC3_CC_W-1:0]   psr,
   input  wire logic [`LC3_CC_W-1:0]   nzp,
   pipe_hazard_if.sequencer            hazard,
   output logic                       enable_update_pc,
   output logic                       enable_fetch,
   output logic                       enable_decode,
   output logic                       enable_execute,
   output logic                       enable_writeback,
   output logic                       br_taken,
   output logic                       pipe_running
);

   // bit positions in the enable vector
   localparam int EN_UPC  = 4;
   localparam int EN_FET  = 3;
   localparam int EN_DEC  = 2;
   localparam int EN_EXE  = 1;
   localparam int EN_WB   = 0;

   pipe_state_e state, next_state;

   logic [4:0] en_raw;    // before masks
   logic [4:0] en_masked; // after branch and store masks
   logic [4:0] prev_en;   // last cycle, post mask
   logic       control_word;
   logic       branch_pending;
   logic       at_resolve;
   logic       at_refill;
   logic       inc;

   // nonzero word with control class on imem output
   assign control_word   = (op_class_e'(instr_dout[13:12]) == OC_CONTROL) &&
                           (instr_dout != '0);
   assign at_resolve     = (hazard.bubble_count == `BUBBLE_W'(`BRANCH_RESOLVE_COUNT));
   assign at_refill      = (hazard.bubble_count == `BUBBLE_W'(`BRANCH_REFILL_COUNT));
   assign branch_pending = control_word &&
                           (hazard.bubble_count < `BUBBLE_W'(`BRANCH_REFILL_COUNT));

   always_comb begin
      en_raw     = '0;
      br_taken   = 1'b0;
      inc        = 1'b0;
      next_state = state;
      case (state)
         PS_RESET: begin
            en_raw[EN_FET] = 1'b1; // hold pc until the first word is back
            if (complete_instr) begin
               en_raw[EN_UPC] = 1'b1;
               next_state     = PS_FILL;
            end
         end
         PS_FILL: begin
            next_state = PS_RUN;
            if (complete_instr && control_word) begin
               en_raw[EN_DEC] = 1'b1; // decode the control word, no new pc
               inc            = 1'b1;
            end
            else begin
               en_raw[EN_FET] = 1'b1;
               en_raw[EN_DEC] = 1'b1;
               en_raw[EN_UPC] = complete_instr;
            end
         end
         PS_RUN: begin
            // back end just shifts, nop kills execute
            en_raw[EN_EXE] = (ir == '0) ? 1'b0 : prev_en[EN_DEC];
            en_raw[EN_WB]  = prev_en[EN_EXE];
            if (complete_instr || branch_pending) begin
               if (!control_word) begin
                  en_raw[EN_UPC] = 1'b1;
                  en_raw[EN_FET] = 1'b1;
                  en_raw[EN_DEC] = prev_en[EN_UPC];
               end
               else begin
                  inc = 1'b1;
                  if (at_resolve) begin
                     // condition test decides the new pc
                     br_taken       = |(psr & nzp);
                     en_raw[EN_UPC] = br_taken;
                  end
                  else if (at_refill) begin
                     en_raw[EN_FET] = 1'b1; // refill from target
                  end
                  else begin
                     en_raw[EN_DEC] = prev_en[EN_FET]; // bubble, drain decode
                  end
               end
            end
            else begin
               // imem word not valid yet
               en_raw[EN_FET] = 1'b1;
               en_raw[EN_DEC] = prev_en[EN_UPC];
            end
         end
         default: begin
            next_state = PS_RESET;
         end
      endcase
   end

   // squash wb of branch slot and of finished store, squash decode at refill
   always_comb begin
      en_masked = en_raw;
      if (at_resolve || hazard.store_done) begin
         en_masked[EN_WB] = 1'b0;
      end
      if (at_refill) begin
         en_masked[EN_DEC] = 1'b0;
      end
   end

   always_ff @(posedge clock) begin
      if (reset) begin
         state   <= PS_RESET;
         prev_en <= '0;
      end
      else if (!hazard.stall) begin // everything holds while memory works
         state   <= next_state;
         prev_en <= en_masked;
      end
   end

   assign {enable_update_pc, enable_fetch, enable_decode, enable_execute,
           enable_writeback} = hazard.stall ? 5'b00000 : en_masked;

   assign hazard.count_inc   = inc;
   assign hazard.count_clear = (state == PS_RESET); // no branch before first fetch
   assign pipe_running       = (state == PS_RUN);

endmodule

`default_nettype wire

// ==== rtl/pipe_hazard_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lc3_ctrl_defines.svh"

interface pipe_hazard_if;

   logic                 stall;        // freeze the whole pipe, from mem ctrl
   logic                 store_done;   // pulse, store data accepted
   logic [`BUBBLE_W-1:0] bubble_count; // cycles since control word
   logic                 count_inc;    // from sequencer
   logic                 count_clear;  // from sequencer

   modport sequencer (
      input  stall, store_done, bubble_count,
      output count_inc, count_clear
   );

   modport counter (
      input  stall, count_inc, count_clear,
      output bubble_count
   );

   modport mem (
      output stall, store_done
   );

endinterface

`default_nettype wire

// ==== rtl/lc3_ctrl_pkg.sv ====
`default_nettype none

package lc3_ctrl_pkg;

   // pipeline sequencer states
   typedef enum logic [1:0] {
      PS_RESET = 2'd0, // fetch only, wait for first word
      PS_FILL  = 2'd1, // fetch + decode, first pass
      PS_RUN   = 2'd2  // steady state
   } pipe_state_e;

   // memory access states, codes go out on mem_state
   typedef enum logic [1:0] {
      MS_LOAD     = 2'd0, // data read
      MS_INDIRECT = 2'd1, // pointer fetch first
      MS_STORE    = 2'd2, // data write
      MS_IDLE     = 2'd3  // no access pending
   } mem_state_e;

   // op class, instruction bits 13:12
   typedef enum logic [1:0] {
      OC_CONTROL = 2'b00, // br / jmp, nonzero word only
      OC_ALU     = 2'b01,
      OC_LOAD    = 2'b10,
      OC_STORE   = 2'b11
   } op_class_e;

   // addressing mode, instruction bits 15:14
   // lea code doubles as jmp within the control class
   typedef enum logic [1:0] {
      AM_BASE     = 2'b01,
      AM_INDIRECT = 2'b10,
      AM_LEA      = 2'b11
   } addr_mode_e;

endpackage

`default_nettype wire

// ==== rtl/lc3_ctrl_defines.svh ====
`ifndef LC3_CTRL_DEFINES_SVH
`define LC3_CTRL_DEFINES_SVH

// instruction word width
`define LC3_WORD_W 16

// register specifier, dr/sr/baser fields
`define LC3_REG_W 3

// condition code and nzp field
`define LC3_CC_W 3

// bubble counter after a control instruction
`define BUBBLE_W 3

// count where the branch is decided, pc update and wb squash
`define BRANCH_RESOLVE_COUNT 2

// count where fetch restarts and decode is squashed
`define BRANCH_REFILL_COUNT 3

`endif
